// ==== common/mpdma_pkg.sv ====
// Shared types and constants for the mirror-padding DMA engine
// Widths, channel payload structs and block geometry

package mpdma_pkg;

    localparam int WORD_BYTES = 4;  // Bytes per data word
    localparam int BLK        = 4;  // Block edge in words
    localparam int BUF_DIM    = 5;  // Pad buffer edge
    localparam int MIN_WIDTH  = 8;
    localparam int MIRROR_POS = 2;  // Buffer row/col that feeds the border

    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [31:0] word_t;
    typedef logic [5:0]  width_t;    // Matrix width in words
    typedef logic [3:0]  blk_idx_t;  // Block coordinate
    typedef logic [2:0]  len_t;      // Burst beats minus one
    typedef logic [2:0]  pos_t;      // Buffer row or column

    // Which matrix edges a block touches
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_t;

    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        width_t width;
    } mpdma_cfg_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } ar_req_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } aw_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } w_beat_t;

endpackage

// ==== mpdma/mpdma_cfg.sv ====
// Start and configuration register for the padding DMA
// Checks the width, latches src/dst/width and owns the done flag

`timescale 1ns/100ps

module mpdma_cfg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mpdma_pkg::addr_t       src_addr_i,
    input  mpdma_pkg::addr_t       dst_addr_i,
    input  mpdma_pkg::width_t      mat_width_i,
    input  logic                   finish_i,
    output logic                   go_o,
    output mpdma_pkg::mpdma_cfg_t  cfg_o,
    output logic                   done_o
);

    logic width_ok;
    logic accept;

    // Multiple of the block edge and at least two blocks wide
    assign width_ok = (mat_width_i >= mpdma_pkg::MIN_WIDTH) &&
                      ((mat_width_i % mpdma_pkg::BLK) == 0);
    assign accept   = start_i && done_o && width_ok;  // Idle only

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_o <= 1'b1;
            go_o   <= 1'b0;
        end else begin
            go_o <= accept;
            if (accept) begin
                done_o <= 1'b0;
            end else if (finish_i) begin
                done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_o.src   <= src_addr_i;
            cfg_o.dst   <= dst_addr_i;
            cfg_o.width <= mat_width_i;
        end
    end

endmodule

// ==== mpdma/pad_buffer.sv ====
// 5x5 block buffer for the padding DMA
// Takes read beats, mirrors row/col 2 into the missing border
// and hands out one word per write beat

`timescale 1ns/100ps

module pad_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              store_i,
    input  mpdma_pkg::pos_t   store_row_i,
    input  mpdma_pkg::pos_t   store_col_i,
    input  mpdma_pkg::word_t  store_data_i,
    input  logic              fill_i,
    input  mpdma_pkg::edge_t  edge_i,
    input  mpdma_pkg::pos_t   out_row_i,
    input  mpdma_pkg::pos_t   out_col_i,
    output mpdma_pkg::word_t  out_word_o
);

    mpdma_pkg::word_t mem_q [mpdma_pkg::BUF_DIM][mpdma_pkg::BUF_DIM];

    // Index to copy from; a border slot on a matrix edge reads the mirror row/col
    function automatic int mirror_src(input int idx, input logic lo_edge, input logic hi_edge);
        int src;
        src = idx;
        if (idx == 0 && lo_edge) begin
            src = mpdma_pkg::MIRROR_POS;
        end else if (idx == mpdma_pkg::BUF_DIM - 1 && hi_edge) begin
            src = mpdma_pkg::MIRROR_POS;
        end
        return src;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n && store_i) begin
            mem_q[store_row_i][store_col_i] <= store_data_i;
        end else if (rst_n && fill_i) begin
            for (int r = 0; r < mpdma_pkg::BUF_DIM; r++) begin
                for (int c = 0; c < mpdma_pkg::BUF_DIM; c++) begin
                    // Corners resolve to [2][2] since both indices move
                    if (mirror_src(r, edge_i.top, edge_i.bottom) != r ||
                        mirror_src(c, edge_i.left, edge_i.right) != c) begin
                        mem_q[r][c] <= mem_q[mirror_src(r, edge_i.top, edge_i.bottom)]
                                            [mirror_src(c, edge_i.left, edge_i.right)];
                    end
                end
            end
        end
    end

    assign out_word_o = mem_q[out_row_i][out_col_i];  // Combinational select

endmodule

// ==== mpdma/mpdma_ctrl.sv ====
// Block walker and AXI channel controller
// Reads each 4x4 block row by row, triggers the border fill,
// then writes one burst per padded destination row

`timescale 1ns/100ps

module mpdma_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go_i,
    input  mpdma_pkg::mpdma_cfg_t  cfg_i,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  logic                   r_last_i,
    input  logic                   awready_i,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    input  mpdma_pkg::word_t       out_word_i,
    output logic                   finish_o,
    output logic                   arvalid_o,
    output mpdma_pkg::ar_req_t     ar_o,
    output logic                   rready_o,
    output logic                   awvalid_o,
    output mpdma_pkg::aw_req_t     aw_o,
    output logic                   wvalid_o,
    output mpdma_pkg::w_beat_t     w_o,
    output logic                   bready_o,
    output logic                   store_o,
    output mpdma_pkg::pos_t        store_row_o,
    output mpdma_pkg::pos_t        store_col_o,
    output logic                   fill_o,
    output mpdma_pkg::edge_t       edge_o,
    output mpdma_pkg::pos_t        out_row_o,
    output mpdma_pkg::pos_t        out_col_o
);

    typedef enum logic [2:0] {
        IDLE, RD_REQ, RD_DATA, FILL, WR_REQ, WR_DATA, WR_RESP
    } state_t;

    state_t               state_q;
    mpdma_pkg::blk_idx_t  blk_x_q, blk_y_q;
    mpdma_pkg::blk_idx_t  last_blk;
    mpdma_pkg::pos_t      rd_row_q, rd_beat_q;
    mpdma_pkg::pos_t      wr_row_q, wr_beat_q;
    mpdma_pkg::pos_t      wr_rows_m1;  // Destination rows in this block, minus one
    mpdma_pkg::len_t      wr_len;
    mpdma_pkg::edge_t     blk_edge;
    mpdma_pkg::addr_t     src_row, dst_row, dst_col, dst_pitch;
    logic                 ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic                 w_last, last_row, last_blk_hit;

    assign last_blk = cfg_i.width[5:2] - 4'd1;  // Square matrix, same in x and y

    assign blk_edge.top    = (blk_y_q == '0);
    assign blk_edge.bottom = (blk_y_q == last_blk);
    assign blk_edge.left   = (blk_x_q == '0);
    assign blk_edge.right  = (blk_x_q == last_blk);

    assign wr_rows_m1   = mpdma_pkg::pos_t'(3 + blk_edge.top + blk_edge.bottom);
    assign wr_len       = mpdma_pkg::len_t'(3 + blk_edge.left + blk_edge.right);
    assign w_last       = (wr_beat_q == wr_len);
    assign last_row     = (wr_row_q == wr_rows_m1);
    assign last_blk_hit = (blk_x_q == last_blk) && (blk_y_q == last_blk);

    assign ar_fire = arvalid_o && arready_i;
    assign r_fire  = rvalid_i && rready_o;
    assign aw_fire = awvalid_o && awready_i;
    assign w_fire  = wvalid_o && wready_i;
    assign b_fire  = bvalid_i && bready_o;

    assign arvalid_o = (state_q == RD_REQ);
    assign rready_o  = (state_q == RD_DATA);
    assign awvalid_o = (state_q == WR_REQ);
    assign wvalid_o  = (state_q == WR_DATA);
    assign bready_o  = (state_q == WR_RESP);  // Only once the W last beat is gone
    assign finish_o  = b_fire && last_row && last_blk_hit;

    // Source pitch is W words
    assign src_row    = mpdma_pkg::addr_t'(blk_y_q) * mpdma_pkg::BLK +
                        mpdma_pkg::addr_t'(rd_row_q);
    assign ar_o.addr  = cfg_i.src + (src_row * mpdma_pkg::addr_t'(cfg_i.width) +
                        mpdma_pkg::addr_t'(blk_x_q) * mpdma_pkg::BLK) * mpdma_pkg::WORD_BYTES;
    assign ar_o.len   = mpdma_pkg::len_t'(mpdma_pkg::BLK - 1);

    // Destination pitch W+2, shifted by one past the leading border
    assign dst_pitch  = mpdma_pkg::addr_t'(cfg_i.width) + 32'd2;
    assign dst_row    = mpdma_pkg::addr_t'(blk_y_q) * mpdma_pkg::BLK +
                        mpdma_pkg::addr_t'(!blk_edge.top) + mpdma_pkg::addr_t'(wr_row_q);
    assign dst_col    = mpdma_pkg::addr_t'(blk_x_q) * mpdma_pkg::BLK +
                        mpdma_pkg::addr_t'(!blk_edge.left);
    assign aw_o.addr  = cfg_i.dst + (dst_row * dst_pitch + dst_col) * mpdma_pkg::WORD_BYTES;
    assign aw_o.len   = wr_len;

    // Data sits one slot in from a top or left border
    assign store_o     = r_fire;
    assign store_row_o = rd_row_q + {2'b00, blk_edge.top};
    assign store_col_o = rd_beat_q + {2'b00, blk_edge.left};
    assign fill_o      = (state_q == FILL);
    assign edge_o      = blk_edge;

    assign out_row_o   = wr_row_q;
    assign out_col_o   = wr_beat_q;
    assign w_o.data    = out_word_i;
    assign w_o.last    = w_last;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            blk_x_q   <= '0;
            blk_y_q   <= '0;
            rd_row_q  <= '0;
            rd_beat_q <= '0;
            wr_row_q  <= '0;
            wr_beat_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (go_i) begin
                        blk_x_q  <= '0;
                        blk_y_q  <= '0;
                        rd_row_q <= '0;
                        state_q  <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (ar_fire) begin
                        rd_beat_q <= '0;
                        state_q   <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_fire) begin
                        rd_beat_q <= rd_beat_q + 3'd1;
                        if (r_last_i && rd_row_q == 3'd3) begin
                            rd_row_q <= '0;
                            state_q  <= FILL;
                        end else if (r_last_i) begin
                            rd_row_q <= rd_row_q + 3'd1;  // Next source row
                            state_q  <= RD_REQ;
                        end
                    end
                end
                FILL: begin
                    wr_row_q <= '0;
                    state_q  <= WR_REQ;
                end
                WR_REQ: begin
                    if (aw_fire) begin
                        wr_beat_q <= '0;
                        state_q   <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        wr_beat_q <= wr_beat_q + 3'd1;
                        if (w_last) begin
                            state_q <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_fire && !last_row) begin
                        wr_row_q <= wr_row_q + 3'd1;
                        state_q  <= WR_REQ;
                    end else if (b_fire && last_blk_hit) begin
                        state_q <= IDLE;
                    end else if (b_fire) begin
                        // Row-major block walk
                        if (blk_x_q == last_blk) begin
                            blk_x_q <= '0;
                            blk_y_q <= blk_y_q + 4'd1;
                        end else begin
                            blk_x_q <= blk_x_q + 4'd1;
                        end
                        state_q <= RD_REQ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== mpdma/mpdma_top.sv ====
// Mirror-padding DMA engine top level
// Joins the start/config register, the block controller and the 5x5 pad buffer

`timescale 1ns/100ps

module mpdma_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  mpdma_pkg::addr_t       src_addr_i,
    input  mpdma_pkg::addr_t       dst_addr_i,
    input  mpdma_pkg::width_t      mat_width_i,
    output logic                   done_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    output mpdma_pkg::ar_req_t     ar_o,
    input  logic                   rvalid_i,
    output logic                   rready_o,
    input  mpdma_pkg::r_beat_t     r_i,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output mpdma_pkg::aw_req_t     aw_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    output mpdma_pkg::w_beat_t     w_o,
    input  logic                   bvalid_i,
    output logic                   bready_o
);

    logic                   go;
    logic                   finish;
    mpdma_pkg::mpdma_cfg_t  cfg;
    logic                   store;
    mpdma_pkg::pos_t        store_row;
    mpdma_pkg::pos_t        store_col;
    logic                   fill;
    mpdma_pkg::edge_t       blk_edge;
    mpdma_pkg::pos_t        out_row;
    mpdma_pkg::pos_t        out_col;
    mpdma_pkg::word_t       out_word;

    mpdma_cfg i_mpdma_cfg (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .finish_i    (finish),
        .go_o        (go),
        .cfg_o       (cfg),
        .done_o      (done_o)
    );

    mpdma_ctrl i_mpdma_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .go_i        (go),
        .cfg_i       (cfg),
        .arready_i   (arready_i),
        .rvalid_i    (rvalid_i),
        .r_last_i    (r_i.last),
        .awready_i   (awready_i),
        .wready_i    (wready_i),
        .bvalid_i    (bvalid_i),
        .out_word_i  (out_word),
        .finish_o    (finish),
        .arvalid_o   (arvalid_o),
        .ar_o        (ar_o),
        .rready_o    (rready_o),
        .awvalid_o   (awvalid_o),
        .aw_o        (aw_o),
        .wvalid_o    (wvalid_o),
        .w_o         (w_o),
        .bready_o    (bready_o),
        .store_o     (store),
        .store_row_o (store_row),
        .store_col_o (store_col),
        .fill_o      (fill),
        .edge_o      (blk_edge),
        .out_row_o   (out_row),
        .out_col_o   (out_col)
    );

    pad_buffer i_pad_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .store_i      (store),
        .store_row_i  (store_row),
        .store_col_i  (store_col),
        .store_data_i (r_i.data),
        .fill_i       (fill),
        .edge_i       (blk_edge),
        .out_row_i    (out_row),
        .out_col_i    (out_col),
        .out_word_o   (out_word)
    );

endmodule

// ==== test/axi_mem_model.sv ====
// AXI-style memory slave for the padding DMA testbench
// Word storage keyed by byte address with random ready and valid delays

`timescale 1ns/100ps

module axi_mem_model (
    input  logic                clk,
    input  logic                bp_en_i,
    input  logic                arvalid_i,
    output logic                arready_o,
    input  mpdma_pkg::ar_req_t  ar_i,
    output logic                rvalid_o,
    input  logic                rready_i,
    output mpdma_pkg::r_beat_t  r_o,
    input  logic                awvalid_i,
    output logic                awready_o,
    input  mpdma_pkg::aw_req_t  aw_i,
    input  logic                wvalid_i,
    output logic                wready_o,
    input  mpdma_pkg::w_beat_t  w_i,
    output logic                bvalid_o,
    input  logic                bready_i
);

    mpdma_pkg::word_t mem [mpdma_pkg::addr_t];
    int ar_count   = 0;  // Accepted read requests
    int w_count    = 0;  // Accepted write beats
    int b_count    = 0;  // Completed write responses
    int w_last_err = 0;  // W beats whose last flag disagrees with the burst length

    function automatic mpdma_pkg::word_t read_word(input mpdma_pkg::addr_t addr);
        mpdma_pkg::word_t value;
        value = 32'h0;
        if (mem.exists(addr)) begin
            value = mem[addr];
        end
        return value;
    endfunction

    task automatic write_word(input mpdma_pkg::addr_t addr, input mpdma_pkg::word_t data);
        mem[addr] = data;
    endtask

    // Zero to three idle cycles under back-pressure
    task automatic random_delay();
        int d;
        d = bp_en_i ? int'($urandom_range(3, 0)) : 0;
        repeat (d) @(negedge clk);
    endtask

    // Read side serves one burst at a time
    initial begin
        mpdma_pkg::ar_req_t req;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        r_o       = '0;
        forever begin
            @(negedge clk);
            if (arvalid_i) begin
                random_delay();
                req = ar_i;  // Payload is held until the transfer
                arready_o = 1'b1;
                @(negedge clk);
                arready_o = 1'b0;
                ar_count++;
                for (int i = 0; i <= int'(req.len); i++) begin
                    random_delay();
                    rvalid_o = 1'b1;
                    r_o.data = read_word(req.addr + mpdma_pkg::addr_t'(i * 4));
                    r_o.last = (i == int'(req.len));
                    while (!rready_i) @(negedge clk);
                    @(negedge clk);
                    rvalid_o = 1'b0;
                end
            end
        end
    end

    // Write side with one response per burst
    initial begin
        mpdma_pkg::aw_req_t req;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        bvalid_o  = 1'b0;
        forever begin
            @(negedge clk);
            if (awvalid_i) begin
                random_delay();
                req = aw_i;
                awready_o = 1'b1;
                @(negedge clk);
                awready_o = 1'b0;
                for (int i = 0; i <= int'(req.len); i++) begin
                    random_delay();
                    wready_o = 1'b1;
                    while (!wvalid_i) @(negedge clk);
                    write_word(req.addr + mpdma_pkg::addr_t'(i * 4), w_i.data);
                    if (w_i.last !== (i == int'(req.len))) begin
                        w_last_err++;
                    end
                    @(negedge clk);
                    wready_o = 1'b0;
                    w_count++;
                end
                random_delay();
                bvalid_o = 1'b1;
                while (!bready_i) @(negedge clk);
                b_count++;  // Both sides high, transfer on the next edge
                @(negedge clk);
                bvalid_o = 1'b0;
            end
        end
    end

endmodule

// ==== test/mpdma_props.sv ====
// Handshake properties for the padding DMA top level
// Stable valid/payload, B after W last, no request while done

`timescale 1ns/100ps

module mpdma_props (
    input logic                clk,
    input logic                rst_n,
    input logic                done_o,
    input logic                arvalid_o,
    input logic                arready_i,
    input mpdma_pkg::ar_req_t  ar_o,
    input logic                rvalid_i,
    input logic                rready_o,
    input mpdma_pkg::r_beat_t  r_i,
    input logic                awvalid_o,
    input logic                awready_i,
    input mpdma_pkg::aw_req_t  aw_o,
    input logic                wvalid_o,
    input logic                wready_i,
    input mpdma_pkg::w_beat_t  w_o,
    input logic                bvalid_i,
    input logic                bready_o
);

    logic w_last_seen;  // W last beat sent, B not yet taken

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_last_seen <= 1'b0;
        end else if (wvalid_o && wready_i && w_o.last) begin
            w_last_seen <= 1'b1;
        end else if (bvalid_i && bready_o) begin
            w_last_seen <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
        else $error("AR valid or payload changed before ready");
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_o |=> rvalid_i && $stable(r_i))
        else $error("R valid or payload changed before ready");
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o))
        else $error("AW valid or payload changed before ready");
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(w_o))
        else $error("W valid or payload changed before ready");
    b_after_w: assert property (@(posedge clk) disable iff (!rst_n)
        bready_o |-> w_last_seen)
        else $error("bready raised before the W last beat");
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_o && (arvalid_o || awvalid_o)))
        else $error("Request issued while done is high");

endmodule

bind mpdma_top mpdma_props i_mpdma_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .done_o    (done_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .ar_o      (ar_o),
    .rvalid_i  (rvalid_i),
    .rready_o  (rready_o),
    .r_i       (r_i),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .aw_o      (aw_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .w_o       (w_o),
    .bvalid_i  (bvalid_i),
    .bready_o  (bready_o)
);

// ==== test/mpdma_tb.sv ====
// Testbench for the mirror-padding DMA engine
// Case table run in a loop, reference padding model and watchdog

`timescale 1ns/100ps

module mpdma_tb;

    typedef struct packed {
        mpdma_pkg::width_t width;
        mpdma_pkg::addr_t  src;
        mpdma_pkg::addr_t  dst;
        logic              bp;          // Random back-pressure
        logic              reuse;       // Keep source of previous case
        logic              busy_start;  // Second start while running
        logic              accept;      // Expected to run
    } case_t;

    localparam int NUM_CASES = 7;
    localparam int GUARD     = 4;  // Guard words on each side of the destination

    case_t cases [NUM_CASES] = '{
        '{6'd8,  32'h0000_1000, 32'h0001_0000, 1'b0, 1'b0, 1'b0, 1'b1},
        '{6'd12, 32'h0000_2000, 32'h0002_0000, 1'b0, 1'b0, 1'b0, 1'b1},
        '{6'd16, 32'h0000_3000, 32'h0003_0000, 1'b0, 1'b0, 1'b0, 1'b1},
        '{6'd16, 32'h0000_3000, 32'h0004_0000, 1'b1, 1'b1, 1'b0, 1'b1},
        '{6'd6,  32'h0000_4000, 32'h0005_0000, 1'b0, 1'b0, 1'b0, 1'b0},
        '{6'd10, 32'h0000_4000, 32'h0006_0000, 1'b0, 1'b0, 1'b0, 1'b0},
        '{6'd12, 32'h0000_5000, 32'h0007_0000, 1'b1, 1'b0, 1'b1, 1'b1}
    };

    logic                   clk;
    logic                   rst_n;
    logic                   start_i;
    mpdma_pkg::addr_t       src_addr;
    mpdma_pkg::addr_t       dst_addr;
    mpdma_pkg::width_t      mat_width;
    logic                   bp_en;
    logic                   done, arvalid, arready, rvalid, rready;
    logic                   awvalid, awready, wvalid, wready, bvalid, bready;
    mpdma_pkg::ar_req_t     ar;
    mpdma_pkg::r_beat_t     r;
    mpdma_pkg::aw_req_t     aw;
    mpdma_pkg::w_beat_t     w;
    mpdma_pkg::word_t       src_words [3600];  // Up to 60x60 source

    mpdma_top i_mpdma_top (
        .clk (clk), .rst_n (rst_n), .start_i (start_i),
        .src_addr_i (src_addr), .dst_addr_i (dst_addr), .mat_width_i (mat_width),
        .done_o (done), .arvalid_o (arvalid), .arready_i (arready), .ar_o (ar),
        .rvalid_i (rvalid), .rready_o (rready), .r_i (r),
        .awvalid_o (awvalid), .awready_i (awready), .aw_o (aw),
        .wvalid_o (wvalid), .wready_i (wready), .w_o (w),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    axi_mem_model i_axi_mem_model (
        .clk (clk), .bp_en_i (bp_en),
        .arvalid_i (arvalid), .arready_o (arready), .ar_i (ar),
        .rvalid_o (rvalid), .rready_i (rready), .r_o (r),
        .awvalid_i (awvalid), .awready_o (awready), .aw_i (aw),
        .wvalid_i (wvalid), .wready_o (wready), .w_i (w),
        .bvalid_o (bvalid), .bready_i (bready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    function automatic mpdma_pkg::word_t guard_word(input mpdma_pkg::addr_t addr);
        return addr ^ 32'hA5C3_5A3C;
    endfunction

    // Mirror index from the padding rule
    function automatic int mirror_idx(input int k, input int width);
        if (k < 0) return 1;
        if (k == width) return width - 2;
        return k;
    endfunction

    task automatic fail_now();
        $display("TEST FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_word(input mpdma_pkg::addr_t addr, input mpdma_pkg::word_t exp);
        mpdma_pkg::word_t got;
        got = i_axi_mem_model.read_word(addr);
        if (got !== exp) begin
            $display("** Error at %0t: word at %h is %h, expected %h", $time, addr, got, exp);
            fail_now();
        end
    endtask

    task automatic check_done(input logic exp);
        if (done !== exp) begin
            $display("** Error at %0t: done_o is %b, expected %b", $time, done, exp);
            fail_now();
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s count is %0d, expected %0d", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic run_case(input int idx);
        case_t            cs;
        int               wd, p, ar0, w0, b0;
        mpdma_pkg::addr_t a;
        mpdma_pkg::word_t exp;
        cs = cases[idx];
        wd = int'(cs.width);
        p  = wd + 2;
        bp_en = cs.bp;
        if (!cs.reuse) begin
            for (int i = 0; i < wd * wd; i++) begin
                src_words[i] = $urandom;
                i_axi_mem_model.write_word(cs.src + mpdma_pkg::addr_t'(i * 4), src_words[i]);
            end
        end
        for (int i = -GUARD; i < p * p + GUARD; i++) begin
            a = cs.dst + mpdma_pkg::addr_t'(i * 4);
            i_axi_mem_model.write_word(a, guard_word(a));
        end
        ar0 = i_axi_mem_model.ar_count;
        w0  = i_axi_mem_model.w_count;
        b0  = i_axi_mem_model.b_count;

        @(negedge clk);
        start_i   = 1'b1;
        src_addr  = cs.src;
        dst_addr  = cs.dst;
        mat_width = cs.width;
        @(negedge clk);
        start_i = 1'b0;

        if (!cs.accept) begin
            repeat (20) begin
                check_done(1'b1);
                check_level("arvalid_o", arvalid, 1'b0);
                @(negedge clk);
            end
            check_count("AR request", i_axi_mem_model.ar_count - ar0, 0);
            check_count("W beat", i_axi_mem_model.w_count - w0, 0);
            for (int i = -GUARD; i < p * p + GUARD; i++) begin
                a = cs.dst + mpdma_pkg::addr_t'(i * 4);
                check_word(a, guard_word(a));
            end
        end else begin
            check_done(1'b0);
            if (cs.busy_start) begin
                start_i  = 1'b1;
                src_addr = 32'h0000_6000;  // Unfilled source would zero the result
                mat_width = 6'd8;
                @(negedge clk);
                start_i = 1'b0;
            end
            while (!done) @(negedge clk);
            check_count("B response", i_axi_mem_model.b_count - b0, (wd / 4) * p);
            check_count("W last mismatch", i_axi_mem_model.w_last_err, 0);
            for (int rr = 0; rr < p; rr++) begin
                for (int cc = 0; cc < p; cc++) begin
                    a   = cs.dst + mpdma_pkg::addr_t'((rr * p + cc) * 4);
                    exp = src_words[mirror_idx(rr - 1, wd) * wd + mirror_idx(cc - 1, wd)];
                    check_word(a, exp);
                    if (cs.reuse) begin
                        check_word(a, i_axi_mem_model.read_word(
                            cases[idx - 1].dst + mpdma_pkg::addr_t'((rr * p + cc) * 4)));
                    end
                end
            end
            for (int i = 0; i < GUARD; i++) begin
                a = cs.dst - mpdma_pkg::addr_t'((i + 1) * 4);
                check_word(a, guard_word(a));
                a = cs.dst + mpdma_pkg::addr_t'((p * p + i) * 4);
                check_word(a, guard_word(a));
            end
        end
    endtask

    // Watchdog sized from the case table
    initial begin
        longint limit;
        limit = 40;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit += longint'((int'(cases[i].width) + 2) ** 2) * 16 + 100;
        end
        #(limit * 8);
        $display("Watchdog expired before the tests completed");
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(71));
        rst_n     = 1'b0;
        start_i   = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        mat_width = '0;
        bp_en     = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_done(1'b1);
        check_level("arvalid_o", arvalid, 1'b0);
        check_level("rready_o", rready, 1'b0);
        check_level("awvalid_o", awvalid, 1'b0);
        check_level("wvalid_o", wvalid, 1'b0);
        check_level("bready_o", bready, 1'b0);
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== sources.f ====
common/mpdma_pkg.sv
mpdma/mpdma_cfg.sv
mpdma/pad_buffer.sv
mpdma/mpdma_ctrl.sv
mpdma/mpdma_top.sv
test/axi_mem_model.sv
test/mpdma_props.sv
test/mpdma_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mpdma_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= sources.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
